//--- x25519_addsub_unit.f
x25519_pkg.sv
x25519_operand_load.sv
x25519_addsub.sv
x25519_freeze.sv
x25519_addsub_unit.sv
x25519_clk_gen.sv
x25519_tb.sv

//--- x25519_tb.sv
`timescale 1ns/1ps

module x25519_tb;

	// ----------------------------------------------------------
	// run length and constants
	// ----------------------------------------------------------
	localparam int n_random = 200; // random operations.
	localparam int n_edge = 5; // edge operand values.
	localparam int n_b2b = 16; // consecutive starts.
	localparam int load_cycles = 16; // two operands, eight words each.
	localparam int drain_cycles = 8; // idle margin after each group.
	localparam int driven_cycles = 8
		+ n_random * (load_cycles + 1) + drain_cycles
		+ n_edge * n_edge * (load_cycles + 2) + drain_cycles
		+ load_cycles + n_b2b + drain_cycles
		+ load_cycles + 3 * (8 + 1) + drain_cycles;
	localparam int cycle_limit = 4 * driven_cycles + 100;
	localparam logic [257:0] p_wide = (258'd1 << 255) - 258'd19; // 2^255 - 19.

	logic clk;
	logic arst_n;
	logic load_en;
	logic load_sel;
	logic [2:0] load_addr;
	logic [31:0] load_data;
	logic start;
	logic op;
	logic result_valid;
	logic [255:0] result;

	logic [31:0] rng_state; // xorshift state.
	logic [255:0] bank_a_m; // model of the a bank.
	logic [255:0] bank_b_m; // model of the b bank.
	logic [255:0] exp_q[$]; // expected residues, in start order.
	int start_q[$]; // edge that sampled each start.
	logic [255:0] edge_vals [n_edge];
	int cycle_cnt = 0; // rising edges seen, written by the monitor only.
	int errors = 0;
	int checks = 0;

	x25519_clk_gen clk_gen_i (
		.clk(clk),
		.arst_n(arst_n)
	);

	x25519_addsub_unit dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.load_sel(load_sel),
		.load_addr(load_addr),
		.load_data(load_data),
		.start(start),
		.op(op),
		.result_valid(result_valid),
		.result(result)
	);

	// ----------------------------------------------------------
	// random numbers and reference model
	// ----------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state); // advance the shared state.
		return rng_state;
	endfunction

	function automatic logic [255:0] rand_elem();
		logic [255:0] v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v[i*32 +: 32] = next_rand(); // eight draws, low word first.
		end
		return v;
	endfunction

	// residue of a+b or a-b, both taken mod p first.
	function automatic logic [255:0] model_result(input logic op_bit,
		input logic [255:0] a, input logic [255:0] b);
		logic [257:0] am;
		logic [257:0] bm;
		logic [257:0] r;
		am = {2'b00, a} % p_wide;
		bm = {2'b00, b} % p_wide;
		if (op_bit) begin
			r = (am + p_wide - bm) % p_wide; // subtract.
		end else begin
			r = (am + bm) % p_wide; // add.
		end
		return r[255:0];
	endfunction

	// ----------------------------------------------------------
	// stimulus tasks, each called at a falling edge
	// ----------------------------------------------------------
	task automatic drive_cycle(input logic do_load, input logic sel, input logic [2:0] addr,
		input logic [31:0] data, input logic do_start, input logic op_bit);
		if (do_start) begin
			exp_q.push_back(model_result(op_bit, bank_a_m, bank_b_m)); // banks before the write.
			start_q.push_back(cycle_cnt + 1); // next rising edge samples start.
		end
		if (do_load) begin
			if (sel) begin
				bank_b_m[addr*32 +: 32] = data;
			end else begin
				bank_a_m[addr*32 +: 32] = data;
			end
		end
		load_en = do_load;
		load_sel = sel;
		load_addr = addr;
		load_data = data;
		start = do_start;
		op = op_bit;
		@(negedge clk);
	endtask

	task automatic load_word(input logic sel, input logic [2:0] addr, input logic [31:0] data);
		drive_cycle(1'b1, sel, addr, data, 1'b0, 1'b0);
	endtask

	task automatic load_elem(input logic sel, input logic [255:0] value);
		for (int i = 0; i < 8; i++) begin
			load_word(sel, i[2:0], value[i*32 +: 32]); // sequential word order.
		end
	endtask

	task automatic issue_op(input logic op_bit);
		drive_cycle(1'b0, 1'b0, 3'd0, 32'd0, 1'b1, op_bit);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(1'b0, 1'b0, 3'd0, 32'd0, 1'b0, 1'b0);
	endtask

	// waits on result_valid pops for a bounded number of cycles.
	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < drain_cycles) begin
			idle_cycles(1);
			waited++;
		end
		idle_cycles(2);
	endtask

	// ----------------------------------------------------------
	// monitor, checks and cycle limit
	// ----------------------------------------------------------
	always @(posedge clk) begin : monitor
		logic [255:0] exp_val;
		int exp_cycle;
		cycle_cnt = cycle_cnt + 1;
		if (arst_n === 1'b1 && $isunknown(result_valid)) begin
			errors++;
			$display("result_valid is unknown after reset at time %0t", $time);
		end else if (result_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("result_valid high with no operation pending at time %0t", $time);
			end else begin
				exp_val = exp_q.pop_front();
				exp_cycle = start_q.pop_front() + 4; // fixed four-cycle latency.
				checks++;
				if (result !== exp_val) begin
					errors++;
					$display("Fail time=%0t signal=result expected=%h actual=%h",
						$time, exp_val, result);
				end
				if (cycle_cnt != exp_cycle) begin
					errors++;
					$display("Fail time=%0t signal=result_valid cycle expected=%0d actual=%0d",
						$time, exp_cycle, cycle_cnt);
				end
				if (result >= p_wide[255:0]) begin
					errors++;
					$display("result %h is not below p at time %0t", result, $time);
				end
			end
		end
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout, run did not finish within %0d cycles", cycle_limit);
			$display("errors: %0d checks: %0d", errors + 1, checks);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin
		int perm [8];
		logic [255:0] a_val;
		logic [255:0] b_val;
		logic [31:0] rnd;
		logic [31:0] data;
		rng_state = 32'd43145; // fixed seed.
		load_en = 1'b0;
		load_sel = 1'b0;
		load_addr = 3'd0;
		load_data = 32'd0;
		start = 1'b0;
		op = 1'b0;
		bank_a_m = '0; // banks clear on reset.
		bank_b_m = '0;
		edge_vals[0] = '0;
		edge_vals[1] = p_wide[255:0] - 256'd1; // p - 1.
		edge_vals[2] = p_wide[255:0]; // p.
		edge_vals[3] = {1'b0, {255{1'b1}}}; // 2^255 - 1.
		edge_vals[4] = '1; // 2^256 - 1.
		perm = '{5, 2, 7, 0, 3, 6, 1, 4};

		// reset state, nothing valid before the first start.
		@(posedge arst_n);
		if (result_valid !== 1'b0) begin
			errors++;
			$display("result_valid not low at reset release, time %0t", $time);
		end
		@(negedge clk);
		for (int i = 0; i < 4; i++) begin
			if (result_valid !== 1'b0) begin
				errors++;
				$display("result_valid high before the first start, time %0t", $time);
			end
			idle_cycles(1);
		end

		// random full-width operands and opcode.
		repeat (n_random) begin
			a_val = rand_elem();
			b_val = rand_elem();
			rnd = next_rand();
			load_elem(1'b0, a_val);
			load_elem(1'b1, b_val);
			issue_op(rnd[0]);
		end
		drain_pipeline();

		// edge operands in every add and subtract pairing.
		for (int i = 0; i < n_edge; i++) begin
			for (int j = 0; j < n_edge; j++) begin
				load_elem(1'b0, edge_vals[i]);
				load_elem(1'b1, edge_vals[j]);
				issue_op(1'b0);
				issue_op(1'b1);
			end
		end
		drain_pipeline();

		// back-to-back starts, each with a word written in the same cycle.
		load_elem(1'b0, rand_elem());
		load_elem(1'b1, rand_elem());
		repeat (n_b2b) begin
			rnd = next_rand();
			data = next_rand();
			drive_cycle(1'b1, rnd[0], rnd[3:1], data, 1'b1, rnd[4]);
		end
		drain_pipeline();

		// shuffled word order gives the same operand as sequential.
		a_val = rand_elem();
		b_val = rand_elem();
		load_elem(1'b0, a_val);
		load_elem(1'b1, b_val);
		issue_op(1'b0);
		load_elem(1'b0, ~a_val); // overwrite every word first.
		issue_op(1'b1);
		for (int k = 0; k < 8; k++) begin
			load_word(1'b0, perm[k][2:0], a_val[perm[k]*32 +: 32]);
		end
		issue_op(1'b0);
		drain_pipeline();

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d operations still pending at end of run", exp_q.size());
		end
		$display("errors: %0d checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- x25519_clk_gen.sv
`timescale 1ns/1ps

module x25519_clk_gen (
	output logic clk,
	output logic arst_n
);

	localparam int half_period = 10; // 20 ns clock.
	localparam int reset_cycles = 5; // rising edges with reset held.

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0; // low from time zero.
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk); // release away from the active edge.
		arst_n = 1'b1;
	end

endmodule

//--- x25519_addsub_unit.sv
`timescale 1ns/1ps

module x25519_addsub_unit (
	input logic clk,
	input logic arst_n,
	input logic load_en, // operand word write.
	input logic load_sel, // 0 is a, 1 is b.
	input logic [x25519_pkg::load_addr_bits-1:0] load_addr, // word index, 0 is lsw.
	input logic [x25519_pkg::word_bits-1:0] load_data,
	input logic start, // launch one operation.
	input logic op, // 0 adds, 1 subtracts.
	output logic result_valid, // four cycles after start.
	output logic [x25519_pkg::elem_bits-1:0] result // residue mod p.
);

	// ----------------------------------------------------------
	// pipeline wires
	// ----------------------------------------------------------
	logic op_valid; // snapshot taken.
	logic op_code;
	logic [x25519_pkg::elem_bits-1:0] op_a;
	logic [x25519_pkg::elem_bits-1:0] op_b;
	logic sum_valid; // unreduced word ready.
	x25519_pkg::unreduced_t sum;

	// ----------------------------------------------------------
	// input side
	// ----------------------------------------------------------
	x25519_operand_load operand_load_i (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.load_sel(load_sel),
		.load_addr(load_addr),
		.load_data(load_data),
		.start(start),
		.op(op),
		.op_valid(op_valid),
		.op_code(op_code),
		.op_a(op_a),
		.op_b(op_b)
	);

	// ----------------------------------------------------------
	// add or biased subtract
	// ----------------------------------------------------------
	x25519_addsub addsub_i (
		.clk(clk),
		.arst_n(arst_n),
		.op_valid(op_valid),
		.op_code(op_code),
		.op_a(op_a),
		.op_b(op_b),
		.sum_valid(sum_valid),
		.sum(sum)
	);

	// ----------------------------------------------------------
	// output side, reduce to canonical
	// ----------------------------------------------------------
	x25519_freeze freeze_i (
		.clk(clk),
		.arst_n(arst_n),
		.en(sum_valid),
		.a(sum),
		.out_valid(result_valid),
		.out(result)
	);

endmodule

//--- x25519_freeze.sv
`timescale 1ns/1ps

module x25519_freeze (
	input logic clk,
	input logic arst_n,
	input logic en, // input word strobe.
	input x25519_pkg::unreduced_t a, // unreduced value, below 2^264.
	output logic out_valid,
	output logic [x25519_pkg::elem_bits-1:0] out // canonical residue in 0..p-1.
);

	// ----------------------------------------------------------
	// stage one, first fold
	// ----------------------------------------------------------
	// 2^255 is 19 mod p, so the bits from 255 up are worth 19 times
	// their value when added back into the low part.
	logic [x25519_pkg::elem_bits-1:0] fold1; // lo + 19*hi, below 2^255 + 9709.
	logic [x25519_pkg::elem_bits-1:0] s1_val;
	logic s1_valid;

	assign fold1 = {1'b0, a.split.lo} + a.split.hi * x25519_pkg::fold_factor;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= en; // stage valid.
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			s1_val <= fold1; // payload, no reset.
		end
	end

	// ----------------------------------------------------------
	// stage two, second fold and final subtract
	// ----------------------------------------------------------
	logic s1_top; // bit 255 of the first fold.
	logic [x25519_pkg::elem_bits-1:0] fold2; // always below 2^255.
	logic [x25519_pkg::elem_bits-1:0] fold2_minus_p;
	logic fold2_ge_p; // fold2 is at least p.
	logic [x25519_pkg::elem_bits-1:0] reduced;

	assign s1_top = s1_val[x25519_pkg::field_bits];

	// if the top bit is set the low part is below 9709, so adding 19
	// cannot carry back into bit 255.
	assign fold2 = {1'b0, s1_val[x25519_pkg::field_bits-1:0]} + s1_top * x25519_pkg::fold_factor;

	assign fold2_minus_p = fold2 - x25519_pkg::prime_p;
	assign fold2_ge_p = (fold2 >= x25519_pkg::prime_p); // only p..2^255-1 get here.
	assign reduced = fold2_ge_p ? fold2_minus_p : fold2; // one subtract is enough.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s1_valid; // two cycles after en.
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			out <= {1'b0, reduced[x25519_pkg::field_bits-1:0]}; // top bit is always zero.
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// holds only if both folds and the final subtract agree over the
	// full input range coming out of add/sub.
	out_canonical: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid |-> (out < x25519_pkg::prime_p)
	) else $error("freeze output not below p");

endmodule

//--- x25519_addsub.sv
`timescale 1ns/1ps

module x25519_addsub (
	input logic clk,
	input logic arst_n,
	input logic op_valid,
	input logic op_code,
	input logic [x25519_pkg::elem_bits-1:0] op_a,
	input logic [x25519_pkg::elem_bits-1:0] op_b,
	output logic sum_valid,
	output x25519_pkg::unreduced_t sum
);

	// ----------------------------------------------------------
	// wide operands
	// ----------------------------------------------------------
	logic [x25519_pkg::wide_bits-1:0] a_ext; // zero-extended a.
	logic [x25519_pkg::wide_bits-1:0] b_ext; // zero-extended b.
	logic [x25519_pkg::wide_bits-1:0] sum_next;

	assign a_ext = {{(x25519_pkg::wide_bits-x25519_pkg::elem_bits){1'b0}}, op_a};
	assign b_ext = {{(x25519_pkg::wide_bits-x25519_pkg::elem_bits){1'b0}}, op_b};

	always_comb begin
		sum_next = '0;
		case (op_code)
			x25519_pkg::op_add: sum_next = a_ext + b_ext; // below 2^257.
			x25519_pkg::op_sub: sum_next = a_ext + x25519_pkg::four_p - b_ext; // 4p > any b.
			default: sum_next = '0;
		endcase
	end

	// ----------------------------------------------------------
	// output register
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= op_valid; // one stage of latency.
		end
	end

	always_ff @(posedge clk) begin
		if (op_valid) begin
			sum.raw <= sum_next; // unreduced, left for freeze.
		end
	end

	// a+4p-b stays below 2^258, so freeze only ever sees three live
	// bits of hi; anything above means the bias or extension broke.
	sum_headroom: assert property (
		@(posedge clk) disable iff (!arst_n)
		sum_valid |-> (sum.raw[x25519_pkg::wide_bits-1:x25519_pkg::elem_bits+2] == '0)
	) else $error("unreduced sum exceeds 2^258");

endmodule

//--- x25519_operand_load.sv
`timescale 1ns/1ps

module x25519_operand_load (
	input logic clk,
	input logic arst_n,
	input logic load_en, // write strobe for one word.
	input logic load_sel, // 0 selects operand a, 1 selects operand b.
	input logic [x25519_pkg::load_addr_bits-1:0] load_addr, // word 0 is least significant.
	input logic [x25519_pkg::word_bits-1:0] load_data,
	input logic start, // launch pulse.
	input logic op, // opcode level, sampled on start.
	output logic op_valid,
	output logic op_code,
	output logic [x25519_pkg::elem_bits-1:0] op_a,
	output logic [x25519_pkg::elem_bits-1:0] op_b
);

	// ----------------------------------------------------------
	// operand banks
	// ----------------------------------------------------------
	// packed so that word 0 lands in bits 31..0 of the flat value.
	logic [x25519_pkg::words_per_elem-1:0][x25519_pkg::word_bits-1:0] bank_a;
	logic [x25519_pkg::words_per_elem-1:0][x25519_pkg::word_bits-1:0] bank_b;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank_a <= '0; // operands come up as zero.
			bank_b <= '0;
		end else if (load_en) begin
			if (load_sel) begin
				bank_b[load_addr] <= load_data; // one word of b.
			end else begin
				bank_a[load_addr] <= load_data; // one word of a.
			end
		end
	end

	// ----------------------------------------------------------
	// snapshot on start
	// ----------------------------------------------------------
	// a load in the same cycle as start is not seen here, since the
	// nonblocking read picks up the bank as it was before the edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= start; // one pulse per start.
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_code <= op; // opcode travels with its operands.
			op_a <= bank_a; // flat 256-bit copy of a.
			op_b <= bank_b; // flat 256-bit copy of b.
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// an unknown opcode would pick an arbitrary path in add/sub and
	// surface four cycles later as a wrong residue.
	op_known_on_start: assert property (
		@(posedge clk) disable iff (!arst_n)
		start |-> !$isunknown(op)
	) else $error("op unknown while start is high");

endmodule

//--- x25519_pkg.sv
package x25519_pkg;

	// ----------------------------------------------------------
	// widths fixed by the field
	// ----------------------------------------------------------
	localparam int field_bits = 255; // value bits of a canonical element.
	localparam int elem_bits = 256; // operand and result width.
	localparam int wide_bits = 264; // unreduced word between add/sub and freeze.
	localparam int word_bits = 32; // one load word.
	localparam int words_per_elem = elem_bits / word_bits; // eight words per operand.
	localparam int load_addr_bits = $clog2(words_per_elem); // word index, 3 bits.

	// ----------------------------------------------------------
	// prime constants
	// ----------------------------------------------------------
	localparam logic [elem_bits-1:0] prime_p = { // p = 2^255 - 19.
		128'h7fff_ffff_ffff_ffff_ffff_ffff_ffff_ffff,
		128'hffff_ffff_ffff_ffff_ffff_ffff_ffff_ffed
	};
	localparam logic [wide_bits-1:0] four_p = { // bias so a - b never goes negative.
		{(wide_bits-elem_bits-2){1'b0}},
		prime_p,
		2'b00
	};
	localparam logic [4:0] fold_factor = 5'd19; // 2^255 == 19 mod p.

	// opcodes.
	localparam logic op_add = 1'b0; // a + b.
	localparam logic op_sub = 1'b1; // a - b.

	// ----------------------------------------------------------
	// unreduced word, read raw or split at bit 255
	// ----------------------------------------------------------
	typedef union packed {
		logic [wide_bits-1:0] raw; // whole 264-bit sum.
		struct packed {
			logic [wide_bits-field_bits-1:0] hi; // bits 263..255, folded back by 19.
			logic [field_bits-1:0] lo; // bits 254..0.
		} split;
	} unreduced_t;

endpackage
